// ==== gtp_bidir_test.sv ====
`default_nettype none

module gtp_bidir_test (
	input  logic                     other_word_clock,
	input  logic                     arst_n,
	input  gtp_test_pkg::lane_word_t sma_rx_data,
	input  logic                     sma_rx_valid,
	input  gtp_test_pkg::lane_word_t sfp_rx_data,
	input  logic                     sfp_rx_valid,
	output gtp_test_pkg::lane_word_t sma_tx_data,
	output logic                     sma_tx_valid,
	output gtp_test_pkg::lane_word_t sfp_tx_data,
	output logic                     sfp_tx_valid,
	output logic                     serial_bit,
	output logic                     serial_valid,
	output logic [3:0]               led,
	output logic                     ready
);

	gtp_test_pkg::rst_stages_t stages;
	gtp_test_pkg::ser_word_t   word_data;
	logic                      word_req;
	logic                      word_ack;
	logic [1:0]                prbs_led;
	logic [1:0]                activity_led;

	reset_sequencer u_reset_sequencer (
		.other_word_clock (other_word_clock),
		.arst_n           (arst_n),
		.stages           (stages),
		.ready            (ready)
	);

	prbs_source u_prbs_source (
		.other_word_clock (other_word_clock),
		.source_rst       (stages.source_rst),
		.word_req         (word_req),
		.word_ack         (word_ack),
		.word_data        (word_data),
		.prbs_led         (prbs_led)
	);

	word_serializer u_word_serializer (
		.other_word_clock (other_word_clock),
		.serializer_rst   (stages.serializer_rst),
		.word_req         (word_req),
		.word_ack         (word_ack),
		.word_data        (word_data),
		.serial_bit       (serial_bit),
		.serial_valid     (serial_valid)
	);

	lane_crossover u_lane_crossover (
		.other_word_clock (other_word_clock),
		.lane_rst         (stages.lane_rst),
		.sma_rx_data      (sma_rx_data),
		.sfp_rx_data      (sfp_rx_data),
		.sma_rx_valid     (sma_rx_valid),
		.sfp_rx_valid     (sfp_rx_valid),
		.sma_tx_data      (sma_tx_data),
		.sfp_tx_data      (sfp_tx_data),
		.sma_tx_valid     (sma_tx_valid),
		.sfp_tx_valid     (sfp_tx_valid),
		.activity_led     (activity_led)
	);

	assign led = {activity_led, prbs_led}; // Lane activity up top, PRBS below

endmodule

`default_nettype wire

// ==== gtp_stimulus.txt ====
# sma_word sma_valid sfp_word sfp_valid exp_sfp_tx exp_sma_tx in hex
# The exp columns hold the word due on the opposite transmit side one cycle later
1a2b 1 0000 0 1a2b 0000
0000 0 c3d4 1 0000 c3d4
beef 1 cafe 1 beef cafe
ffff 1 0001 1 ffff 0001
0000 0 0000 0 0000 0000
8000 1 7fff 0 8000 0000
1234 0 4321 1 0000 4321
a5a5 1 5a5a 1 a5a5 5a5a
0f0f 1 0000 0 0f0f 0000
0000 0 f0f0 1 0000 f0f0
dead 1 d00d 1 dead d00d
0001 1 8000 1 0001 8000
7e7e 0 e7e7 0 0000 0000

// ==== gtp_test_cfg.svh ====
`ifndef GTP_TEST_CFG_SVH
`define GTP_TEST_CFG_SVH

// Serializer payload word, one OSERDES load
`define GTP_SER_WIDTH 8

// Transceiver lane word
`define GTP_LANE_WIDTH 16

// Counter bit that frees the first reset stage; next stages use the next two bits
// Small for simulation, hardware wants something near 14
`define GTP_RST_PICKOFF 3

// Cycles an activity LED stays lit after the last valid word
`define GTP_ACT_HOLD 6

// PRBS-15 start value
`define GTP_PRBS_SEED 15'h7fff

`endif

// ==== gtp_test_pkg.sv ====
`default_nettype none

`include "gtp_test_cfg.svh"

package gtp_test_pkg;

	// One word handed to the serializer
	typedef logic [`GTP_SER_WIDTH-1:0] ser_word_t;

	// One transceiver lane word
	typedef logic [`GTP_LANE_WIDTH-1:0] lane_word_t;

	// Staged resets, all active high
	typedef struct packed {
		logic serializer_rst; // Released first
		logic source_rst;
		logic lane_rst;       // Released last
	} rst_stages_t;

endpackage

`default_nettype wire

// ==== lane_crossover.sv ====
`default_nettype none

`include "gtp_test_cfg.svh"

module lane_crossover (
	input  logic                     other_word_clock,
	input  logic                     lane_rst,
	input  gtp_test_pkg::lane_word_t sma_rx_data,
	input  gtp_test_pkg::lane_word_t sfp_rx_data,
	input  logic                     sma_rx_valid,
	input  logic                     sfp_rx_valid,
	output gtp_test_pkg::lane_word_t sma_tx_data,
	output gtp_test_pkg::lane_word_t sfp_tx_data,
	output logic                     sma_tx_valid,
	output logic                     sfp_tx_valid,
	output logic [1:0]               activity_led
);

	localparam int unsigned HOLD_W = $clog2(`GTP_ACT_HOLD + 1);

	// Index 1 is the SMA lane, index 0 the SFP lane
	gtp_test_pkg::lane_word_t rx_data [2];
	gtp_test_pkg::lane_word_t tx_data [2];
	logic [1:0]               rx_valid;
	logic [1:0]               tx_valid;

	assign rx_data[1] = sma_rx_data;
	assign rx_data[0] = sfp_rx_data;
	assign rx_valid   = {sma_rx_valid, sfp_rx_valid};

	for (genvar i = 0; i < 2; i++) begin : g_lane
		logic [HOLD_W-1:0] hold_cnt;

		// Word from this receiver goes out on the other transmitter
		always_ff @(posedge other_word_clock) begin
			if (rx_valid[i]) begin
				tx_data[1-i] <= rx_data[i];
			end
		end

		always_ff @(posedge other_word_clock) begin
			if (lane_rst) begin
				tx_valid[1-i] <= 1'b0;
				hold_cnt      <= '0;
			end else begin
				tx_valid[1-i] <= rx_valid[i];
				if (rx_valid[i]) begin
					hold_cnt <= HOLD_W'(`GTP_ACT_HOLD);
				end else if (hold_cnt != '0) begin
					hold_cnt <= hold_cnt - 1'b1;
				end
			end
		end

		assign activity_led[i] = hold_cnt != '0;
	end

	assign sma_tx_data  = tx_data[1];
	assign sfp_tx_data  = tx_data[0];
	assign sma_tx_valid = tx_valid[1];
	assign sfp_tx_valid = tx_valid[0];

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
gtp_test_pkg.sv
reset_sequencer.sv
prbs_source.sv
word_serializer.sv
lane_crossover.sv
gtp_bidir_test.sv
tb_gtp_bidir_test.sv

// ==== prbs_source.sv ====
`default_nettype none

`include "gtp_test_cfg.svh"

module prbs_source (
	input  logic                    other_word_clock,
	input  logic                    source_rst,
	output logic                    word_req,
	input  logic                    word_ack,
	output gtp_test_pkg::ser_word_t word_data,
	output logic [1:0]              prbs_led
);

	localparam int unsigned SW = `GTP_SER_WIDTH;

	logic [14:0] lfsr;
	logic [14:0] lfsr_adv;
	gtp_test_pkg::ser_word_t word_next;

	// Fibonacci PRBS-15, taps 15 and 14
	// Each step emits the bit shifted out of the top, oldest bit lands at the word MSB
	always_comb begin
		lfsr_adv = lfsr;
		for (int i = SW - 1; i >= 0; i--) begin
			word_next[i] = lfsr_adv[14];
			lfsr_adv = {lfsr_adv[13:0], lfsr_adv[14] ^ lfsr_adv[13]};
		end
	end

	// Offer side of the four-phase handshake
	always_ff @(posedge other_word_clock) begin
		if (source_rst) begin
			word_req <= 1'b0;
			lfsr     <= `GTP_PRBS_SEED;
		end else if (!word_req && !word_ack) begin
			word_req <= 1'b1;
		end else if (word_req && word_ack) begin
			word_req <= 1'b0;
			lfsr     <= lfsr_adv; // Word taken, move on
		end
	end

	// Held steady by the LFSR while word_req is up
	assign word_data = word_next;
	assign prbs_led  = word_next[1:0];

endmodule

`default_nettype wire

// ==== reset_sequencer.sv ====
`default_nettype none

`include "gtp_test_cfg.svh"

module reset_sequencer (
	input  logic                      other_word_clock,
	input  logic                      arst_n,
	output gtp_test_pkg::rst_stages_t stages,
	output logic                      ready
);

	localparam int unsigned PICK  = `GTP_RST_PICKOFF;
	localparam int unsigned CNT_W = PICK + 3;

	logic [CNT_W-1:0] counter;

	// Free-running until the lane stage lets go, then parked
	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			counter <= '0;
		end else if (stages.lane_rst) begin
			counter <= counter + 1'b1;
		end
	end

	// Sticky release flags, one pick-off bit per stage
	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			stages <= '1;
		end else begin
			if (counter[PICK]) begin
				stages.serializer_rst <= 1'b0;
			end
			if (counter[PICK+1]) begin
				stages.source_rst <= 1'b0;
			end
			if (counter[PICK+2]) begin
				stages.lane_rst <= 1'b0;
			end
		end
	end

	always_ff @(posedge other_word_clock or negedge arst_n) begin
		if (!arst_n) begin
			ready <= 1'b0;
		end else if (!stages.lane_rst) begin
			ready <= 1'b1; // Stays up until the next arst_n
		end
	end

endmodule

`default_nettype wire

// ==== tb_gtp_bidir_test.sv ====
`default_nettype none

`include "gtp_test_cfg.svh"

module tb_gtp_bidir_test;

	localparam int PICK       = `GTP_RST_PICKOFF;
	localparam int HOLD       = `GTP_ACT_HOLD;
	localparam int SW         = `GTP_SER_WIDTH;
	localparam int NUM_SERIAL = 64;

	logic                     other_word_clock = 1'b0;
	logic                     arst_n;
	gtp_test_pkg::lane_word_t sma_rx_data;
	logic                     sma_rx_valid;
	gtp_test_pkg::lane_word_t sfp_rx_data;
	logic                     sfp_rx_valid;
	gtp_test_pkg::lane_word_t sma_tx_data;
	logic                     sma_tx_valid;
	gtp_test_pkg::lane_word_t sfp_tx_data;
	logic                     sfp_tx_valid;
	logic                     serial_bit;
	logic                     serial_valid;
	logic [3:0]               led;
	logic                     ready;

	gtp_test_pkg::lane_word_t stim_sma[$];
	gtp_test_pkg::lane_word_t stim_sfp[$];
	logic                     stim_sma_v[$];
	logic                     stim_sfp_v[$];
	gtp_test_pkg::lane_word_t exp_to_sfp[$];
	gtp_test_pkg::lane_word_t exp_to_sma[$];
	gtp_test_pkg::lane_word_t to_sfp_q[$]; // Words in flight, one cycle deep
	gtp_test_pkg::lane_word_t to_sma_q[$];

	int err_file   = 0;
	int err_reset  = 0;
	int err_to_sfp = 0;
	int err_to_sma = 0;
	int err_serial = 0;
	int err_led    = 0;

	int          cycle_count = 0;
	int          cycle_limit = 2 ** (PICK + 4) + NUM_SERIAL * 16;
	logic [31:0] lcg_state   = 32'd21795;

	gtp_test_pkg::ser_word_t prbs_words [NUM_SERIAL];
	gtp_test_pkg::ser_word_t serial_acc;
	int                      serial_bits  = 0;
	int                      serial_words = 0;

	gtp_bidir_test u_dut (
		.other_word_clock (other_word_clock),
		.arst_n           (arst_n),
		.sma_rx_data      (sma_rx_data),
		.sma_rx_valid     (sma_rx_valid),
		.sfp_rx_data      (sfp_rx_data),
		.sfp_rx_valid     (sfp_rx_valid),
		.sma_tx_data      (sma_tx_data),
		.sma_tx_valid     (sma_tx_valid),
		.sfp_tx_data      (sfp_tx_data),
		.sfp_tx_valid     (sfp_tx_valid),
		.serial_bit       (serial_bit),
		.serial_valid     (serial_valid),
		.led              (led),
		.ready            (ready)
	);

	initial begin
		forever #4 other_word_clock = ~other_word_clock;
	end

	always @(posedge other_word_clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("Timeout after %0d cycles, the test never reached its end", cycle_limit);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// PRBS-15 bit recurrence s[n+15] = s[n] ^ s[n+1], oldest bit to the word MSB
	task automatic build_prbs_words();
		logic        bits[$];
		logic [14:0] seed;
		seed = `GTP_PRBS_SEED;
		for (int i = 14; i >= 0; i--) begin
			bits.push_back(seed[i]);
		end
		for (int w = 0; w < NUM_SERIAL; w++) begin
			for (int i = SW - 1; i >= 0; i--) begin
				bits.push_back(bits[0] ^ bits[1]);
				prbs_words[w][i] = bits.pop_front();
			end
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act,
			inout int errs);
		if (act !== exp) begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			errs++;
		end
	endtask

	task automatic check_lane(input string name, input gtp_test_pkg::lane_word_t exp,
			input gtp_test_pkg::lane_word_t act, inout int errs);
		if (act !== exp) begin
			$display("ERROR %s expected %h got %h", name, exp, act);
			errs++;
		end
	endtask

	task automatic check_serial(input int index, input gtp_test_pkg::ser_word_t exp,
			input gtp_test_pkg::ser_word_t act, inout int errs);
		if (act !== exp) begin
			$display("ERROR serial_bit word %0d expected %h got %h", index, exp, act);
			errs++;
		end
	endtask

	task automatic check_led(input string name, input logic [3:0] exp, input logic [3:0] act,
			input logic [3:0] mask, inout int errs);
		if ((act & mask) !== (exp & mask)) begin
			$display("ERROR %s expected %h got %h", name, exp & mask, act & mask);
			errs++;
		end
	endtask

	task automatic report_test(input string name, input int errs);
		if (errs == 0) begin
			$display("Test %s done with no errors", name);
		end else begin
			$display("Test %s done with %0d errors", name, errs);
		end
	endtask

	task automatic read_stimulus();
		int                       fd;
		int                       n;
		int                       c;
		gtp_test_pkg::lane_word_t sma_w;
		gtp_test_pkg::lane_word_t sfp_w;
		gtp_test_pkg::lane_word_t to_sfp;
		gtp_test_pkg::lane_word_t to_sma;
		logic                     sma_v;
		logic                     sfp_v;
		fd = $fopen("gtp_stimulus.txt", "r");
		if (fd == 0) begin
			$display("Could not open gtp_stimulus.txt for reading");
			err_file++;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, " %h %h %h %h %h %h", sma_w, sma_v, sfp_w, sfp_v,
					to_sfp, to_sma);
				if (n == 6) begin
					stim_sma.push_back(sma_w);
					stim_sma_v.push_back(sma_v);
					stim_sfp.push_back(sfp_w);
					stim_sfp_v.push_back(sfp_v);
					exp_to_sfp.push_back(to_sfp);
					exp_to_sma.push_back(to_sma);
				end else begin
					c = $fgetc(fd); // Comment line, drop the rest of it
					while (c != "\n" && c != -1) begin
						c = $fgetc(fd);
					end
				end
			end
			$fclose(fd);
			if (stim_sma.size() == 0) begin
				$display("No stimulus lines found in gtp_stimulus.txt");
				err_file++;
			end
		end
	endtask

	// Whatever went in last cycle must come out now on the opposite side
	task automatic check_lanes();
		gtp_test_pkg::lane_word_t exp;
		check_flag("sfp_tx_valid", to_sfp_q.size() != 0, sfp_tx_valid, err_to_sfp);
		if (to_sfp_q.size() != 0) begin
			exp = to_sfp_q.pop_front();
			if (sfp_tx_valid) check_lane("sfp_tx_data", exp, sfp_tx_data, err_to_sfp);
		end
		check_flag("sma_tx_valid", to_sma_q.size() != 0, sma_tx_valid, err_to_sma);
		if (to_sma_q.size() != 0) begin
			exp = to_sma_q.pop_front();
			if (sma_tx_valid) check_lane("sma_tx_data", exp, sma_tx_data, err_to_sma);
		end
	endtask

	task automatic drive_cycle(input gtp_test_pkg::lane_word_t sma_w, input logic sma_v,
			input gtp_test_pkg::lane_word_t sfp_w, input logic sfp_v,
			input gtp_test_pkg::lane_word_t to_sfp, input gtp_test_pkg::lane_word_t to_sma);
		@(negedge other_word_clock);
		check_lanes();
		sma_rx_data  = sma_w;
		sma_rx_valid = sma_v;
		sfp_rx_data  = sfp_w;
		sfp_rx_valid = sfp_v;
		if (sma_v) to_sfp_q.push_back(to_sfp);
		if (sfp_v) to_sma_q.push_back(to_sma);
	endtask

	task automatic drive_idle();
		drive_cycle('0, 1'b0, '0, 1'b0, '0, '0);
	endtask

	task automatic check_reset_outputs(input logic serial_quiet, input logic source_held);
		check_flag("sma_tx_valid", 1'b0, sma_tx_valid, err_reset);
		check_flag("sfp_tx_valid", 1'b0, sfp_tx_valid, err_reset);
		if (serial_quiet) check_flag("serial_valid", 1'b0, serial_valid, err_reset);
		check_led("led", {2'b00, prbs_words[0][1:0]}, led,
			source_held ? 4'hf : 4'hc, err_reset);
	endtask

	// One word on a lane, then its LED must hold for HOLD cycles
	task automatic led_hold_test(input logic sma_lane);
		logic [31:0]              r;
		gtp_test_pkg::lane_word_t w;
		logic [3:0]               exp;
		r = lcg_next();
		w = r[31:16];
		if (sma_lane) drive_cycle(w, 1'b1, '0, 1'b0, w, '0);
		else drive_cycle('0, 1'b0, w, 1'b1, '0, w);
		for (int i = 1; i <= HOLD + 1; i++) begin
			drive_idle();
			exp = '0;
			if (i <= HOLD) exp[sma_lane ? 3 : 2] = 1'b1;
			check_led(sma_lane ? "led[3]" : "led[2]", exp, led, 4'hc, err_led);
		end
	endtask

	// Serial words reassembled MSB first
	always @(negedge other_word_clock) begin
		if (serial_valid === 1'b1 && serial_words < NUM_SERIAL) begin
			serial_acc = {serial_acc[SW-2:0], serial_bit};
			serial_bits++;
			if (serial_bits == SW) begin
				check_serial(serial_words, prbs_words[serial_words], serial_acc, err_serial);
				serial_bits = 0;
				serial_words++;
			end
		end
	end

	initial begin
		logic [31:0] r;
		int          since_release;
		int          total;
		arst_n       = 1'b0;
		sma_rx_data  = 16'h5a5a; // Valid traffic during reset must not pass
		sma_rx_valid = 1'b1;
		sfp_rx_data  = 16'ha5a5;
		sfp_rx_valid = 1'b1;
		read_stimulus();
		cycle_limit = cycle_limit + stim_sma.size() * 6;
		build_prbs_words();

		// Block resets come from the stage registers, one edge after arst_n
		for (int i = 0; i < 3; i++) begin
			@(negedge other_word_clock);
			if (i > 0) begin
				check_reset_outputs(1'b1, 1'b1);
			end
		end
		arst_n = 1'b1;
		since_release = 0;
		while (ready !== 1'b1) begin
			@(negedge other_word_clock);
			since_release++;
			if (ready !== 1'b1) begin
				check_reset_outputs(since_release <= 2 ** PICK,
					since_release <= 2 ** (PICK + 1));
			end
		end
		// Lane stage frees one edge after its pick-off bit sets, ready one edge later
		if (since_release != 2 ** (PICK + 2) + 2) begin
			$display("ERROR ready rise cycle expected %h got %h", 2 ** (PICK + 2) + 2,
				since_release);
			err_reset++;
		end
		sma_rx_valid = 1'b0;
		sfp_rx_valid = 1'b0;
		repeat (HOLD + 2) @(negedge other_word_clock); // Let the reset-time words drain
		report_test("reset release", err_reset);

		for (int n = 0; n < stim_sma.size(); n++) begin
			drive_cycle(stim_sma[n], stim_sma_v[n], stim_sfp[n], stim_sfp_v[n],
				exp_to_sfp[n], exp_to_sma[n]);
			r = lcg_next();
			repeat (r[17:16]) drive_idle();
		end
		repeat (HOLD + 2) drive_idle();
		report_test("crossover sma to sfp", err_to_sfp);
		report_test("crossover sfp to sma", err_to_sma);

		led_hold_test(1'b1);
		led_hold_test(1'b0);
		report_test("activity and prbs leds", err_led);

		while (serial_words < NUM_SERIAL) @(negedge other_word_clock);
		report_test("serial prbs", err_serial);

		total = err_file + err_reset + err_to_sfp + err_to_sma + err_serial + err_led;
		$display("Errors %0d: file %0d reset %0d to_sfp %0d to_sma %0d serial %0d led %0d",
			total, err_file, err_reset, err_to_sfp, err_to_sma, err_serial, err_led);
		if (total == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== word_serializer.sv ====
`default_nettype none

`include "gtp_test_cfg.svh"

module word_serializer (
	input  logic                    other_word_clock,
	input  logic                    serializer_rst,
	input  logic                    word_req,
	output logic                    word_ack,
	input  gtp_test_pkg::ser_word_t word_data,
	output logic                    serial_bit,
	output logic                    serial_valid
);

	localparam int unsigned SW    = `GTP_SER_WIDTH;
	localparam int unsigned CNT_W = $clog2(SW);
	localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SW - 1);

	gtp_test_pkg::ser_word_t hold_q;
	gtp_test_pkg::ser_word_t shift_q;
	logic                    hold_full;
	logic [CNT_W-1:0]        bit_cnt;
	logic                    take;
	logic                    load;
	logic                    shift;

	assign take  = word_req && !word_ack && !hold_full; // Back-pressure via hold_full
	assign load  = hold_full && (!serial_valid || bit_cnt == LAST_BIT);
	assign shift = serial_valid && bit_cnt != LAST_BIT;

	always_ff @(posedge other_word_clock) begin
		if (serializer_rst) begin
			word_ack     <= 1'b0;
			hold_full    <= 1'b0;
			serial_valid <= 1'b0;
			bit_cnt      <= '0;
		end else begin
			if (take) begin
				hold_full <= 1'b1;
				word_ack  <= 1'b1;
			end else if (word_ack && !word_req) begin
				word_ack <= 1'b0;
			end

			if (load) begin
				hold_full    <= 1'b0;
				serial_valid <= 1'b1;
				bit_cnt      <= '0;
			end else if (shift) begin
				bit_cnt <= bit_cnt + 1'b1;
			end else begin
				serial_valid <= 1'b0; // Ran dry after the last bit
			end
		end
	end

	always_ff @(posedge other_word_clock) begin
		if (take) begin
			hold_q <= word_data;
		end
		if (load) begin
			shift_q <= hold_q;
		end else if (shift) begin
			shift_q <= {shift_q[SW-2:0], 1'b0};
		end
	end

	assign serial_bit = shift_q[SW-1]; // MSB first

endmodule

`default_nettype wire
